// File: build.f
+incdir+logic
logic/dds_pkg.sv
logic/kbd_pkg.sv
logic/dds_wave_if.sv
logic/tick_divider.sv
logic/rate_lfsr.sv
logic/sine_lookup.sv
logic/dds_core.sv
logic/sample_select.sv
logic/key_state_tracker.sv
logic/dds_lab_top.sv
verif/dds_lab_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dds lab testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module dds_lab_tb -o dds_lab_sim

./obj_dir/dds_lab_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

// File: verif/dds_lab_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dds_macros.svh"

module dds_lab_tb;

   localparam int rate_div_tb   = 64;
   localparam int sample_div_tb = 16;
   localparam int strobe_limit  = 2 * sample_div_tb + 4;
   localparam dds_pkg::wave_sample_t full_pos = 12'sh7FF;
   localparam dds_pkg::wave_sample_t full_neg = 12'sh800;

   logic                  CLK_25MHZ;
   logic                  reset_from_key;
   dds_pkg::wave_sel_e    signal_select;
   logic                  event_ready;
   kbd_pkg::scan_event_e  event_code;
   dds_pkg::wave_sample_t sample;
   logic                  sample_strobe;
   logic                  rate_fast;
   kbd_pkg::held_keys_t   keys;

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   logic        timed_out = 1'b0;
   logic [31:0] rng = 32'd85288;

   dds_lab_top #(.rate_div(rate_div_tb), .sample_div(sample_div_tb)) i_dds_lab_top
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .signal_select  (signal_select),
      .event_ready    (event_ready),
      .event_code     (event_code),
      .sample         (sample),
      .sample_strobe  (sample_strobe),
      .rate_fast      (rate_fast),
      .keys           (keys)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   // 32-bit fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
         rng = {rng[30:0], fb};
         r   = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic next_cycle();
      @(posedge CLK_25MHZ);
      #5;                                  // drive and sample point
   endtask

   task automatic apply_reset();
      reset_from_key = 1'b1;
      repeat (16) next_cycle();
      reset_from_key = 1'b0;
   endtask

   task automatic wait_strobe(input int limit);
      int n;
      n = 0;
      do
      begin
         next_cycle();
         n++;
      end
      while (!sample_strobe && n < limit);
      if (!sample_strobe)
      begin
         timed_out = 1'b1;
         errors++;
         $display("timeout: no sample strobe within %0d cycles", limit);
      end
   endtask

   task automatic wait_rate_change(input int limit, output int cycles);
      logic last;
      last   = rate_fast;
      cycles = 0;
      while (rate_fast == last && cycles < limit)
      begin
         next_cycle();
         cycles++;
      end
      if (rate_fast == last)
      begin
         timed_out = 1'b1;
         errors++;
         $display("timeout: rate_fast did not change within %0d cycles", limit);
      end
   endtask

   task automatic check_sample(input string what, input dds_pkg::wave_sample_t got,
                               input dds_pkg::wave_sample_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_keys(input string what, input kbd_pkg::held_keys_t got,
                             input kbd_pkg::held_keys_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      $display("test %-14s %s", name, (errors == err_before) ? "ok" : "failed");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset_state();
      int err0;
      int n;
      err0 = errors;
      apply_reset();
      check_sample("sample after reset", sample, '0);
      check_keys("keys after reset", keys, '0);
      check_bit("rate_fast after reset", rate_fast, 1'b1);
      check_bit("sample_strobe after reset", sample_strobe, 1'b0);
      n = 0;
      while (!sample_strobe && n < strobe_limit)
      begin
         check_sample("sample before first strobe", sample, '0);
         next_cycle();
         n++;
      end
      if (!sample_strobe)
      begin
         timed_out = 1'b1;
         errors++;
         $display("timeout: first sample strobe never arrived");
      end
      report_test("reset state", err0);
   endtask

   task automatic test_rate_lfsr();
      logic [4:0] st;
      logic       cur;
      int         run;
      int         runs[$];
      logic       vals[$];
      int         cycles;
      int         exp_cycles;
      int         err0;
      err0 = errors;
      // model: new bit = bit 4 ^ bit 2, shifted in at bit 0
      st  = 5'b00001;
      cur = 1'b1;
      run = 0;
      while (runs.size() < 8)
      begin
         st = {st[3:0], st[4] ^ st[2]};
         run++;
         if (st[0] != cur)
         begin
            runs.push_back(run);
            vals.push_back(st[0]);
            cur = st[0];
            run = 0;
         end
      end
      apply_reset();
      for (int k = 0; k < 8; k++)
      begin
         wait_rate_change(8 * rate_div_tb, cycles);
         if (timed_out)
            break;
         exp_cycles = runs[k] * rate_div_tb + ((k == 0) ? 1 : 0);   // shift lags tick
         check_bit($sformatf("rate_fast at change %0d", k), rate_fast, vals[k]);
         check_bit($sformatf("change %0d after %0d cycles, expected %0d", k, cycles,
                   exp_cycles), cycles == exp_cycles, 1'b1);
      end
      report_test("rate lfsr", err0);
   endtask

   task automatic test_sawtooth();
      dds_pkg::wave_sample_t prev;
      logic                  prev_rate;
      logic [31:0]           inc;
      logic [11:0]           step;
      logic [11:0]           diff;
      int                    err0;
      err0 = errors;
      signal_select = dds_pkg::WAVE_SAW;
      wait_strobe(strobe_limit);           // flush the old selection
      if (!timed_out)
         wait_strobe(strobe_limit);
      prev      = sample;
      prev_rate = rate_fast;
      for (int k = 0; k < 40 && !timed_out; k++)
      begin
         wait_strobe(strobe_limit);
         if (timed_out)
            break;
         if (rate_fast == prev_rate)       // skip pairs across a rate change
         begin
            inc  = rate_fast ? `DDS_INC_FAST : `DDS_INC_SLOW;
            step = 12'((sample_div_tb * inc) >> 20);
            diff = 12'(sample) - 12'(prev) - step;
            if (diff == 12'd0 || diff == 12'd1 || diff == 12'hFFF)
               checks++;
            else
               check_sample("saw step", sample, dds_pkg::wave_sample_t'(12'(prev) + step));
         end
         prev      = sample;
         prev_rate = rate_fast;
      end
      report_test("sawtooth", err0);
   endtask

   task automatic test_wave_range();
      dds_pkg::wave_sel_e    sel;
      dds_pkg::wave_sample_t s;
      int                    err0;
      err0 = errors;
      for (int r = 0; r < 6 && !timed_out; r++)
      begin
         sel = dds_pkg::wave_sel_e'(2'(take_bits(2)));
         if (sel == dds_pkg::WAVE_SAW)
            sel = dds_pkg::WAVE_SQUARE;
         signal_select = sel;
         wait_strobe(strobe_limit);
         for (int j = 0; j < 8 && !timed_out; j++)
         begin
            wait_strobe(strobe_limit);
            if (timed_out)
               break;
            s = sample;
            if (sel == dds_pkg::WAVE_SQUARE)
               check_bit($sformatf("square sample %0d at full scale", s),
                         s == full_pos || s == full_neg, 1'b1);
            else
               check_bit($sformatf("%s sample %0d within 2047", sel.name(), s),
                         s >= -12'sd2047 && s <= full_pos, 1'b1);
         end
      end
      report_test("wave range", err0);
   endtask

   task automatic test_key_tracking();
      kbd_pkg::held_keys_t model;
      logic [4:0]          idx;
      logic                brk;
      logic [7:0]          code;
      int                  err0;
      err0  = errors;
      model = '0;                          // no events since reset
      check_keys("keys before events", keys, model);
      for (int k = 0; k < 48; k++)
      begin
         idx  = 5'(take_bits(5));
         brk  = take_bits(1) != 0;
         code = {brk, 2'b00, 5'(idx + 5'd1)};
         if (idx == 5'd31)
            code = {brk, 7'd0};            // code zero, never a key
         event_code  = kbd_pkg::scan_event_e'(code);
         event_ready = 1'b1;
         next_cycle();
         event_ready = 1'b0;
         if (code[6:0] >= 7'd1 && code[6:0] <= 7'd17)
            model[code[6:0] - 7'd1] = !code[7];
         check_keys($sformatf("keys after code %h", code), keys, model);
         // a code without ready must change nothing
         event_code = kbd_pkg::scan_event_e'(8'(take_bits(8)));
         next_cycle();
         check_keys("keys with ready low", keys, model);
      end
      report_test("key tracking", err0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      reset_from_key = 1'b1;
      signal_select  = dds_pkg::WAVE_SINE;
      event_ready    = 1'b0;
      event_code     = kbd_pkg::SC_NONE;

      if (!timed_out)
         test_reset_state();
      if (!timed_out)
         test_rate_lfsr();
      if (!timed_out)
         test_sawtooth();
      if (!timed_out)
         test_wave_range();
      if (!timed_out)
         test_key_tracking();

      $display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0 && !timed_out)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/dds_lab_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dds_macros.svh"

module dds_lab_top
#(
   parameter int unsigned rate_div   = `RATE_TICK_DIV,
   parameter int unsigned sample_div = `SAMPLE_DIV
)
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_pkg::wave_sel_e    signal_select,
   input  logic                  event_ready,
   input  kbd_pkg::scan_event_e  event_code,
   output dds_pkg::wave_sample_t sample,
   output logic                  sample_strobe,
   output logic                  rate_fast,
   output kbd_pkg::held_keys_t   keys
);

   ////////////////////////////////////////////////////////////////////////////
   // rate control
   ////////////////////////////////////////////////////////////////////////////

   logic rate_tick;
   logic sample_tick;

   tick_divider #(.div(rate_div)) i_rate_tick
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tick           (rate_tick)
   );

   rate_lfsr i_rate_lfsr
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tick           (rate_tick),
      .rate_fast      (rate_fast)        // also drives the increment mux
   );

   ////////////////////////////////////////////////////////////////////////////
   // waveform path
   ////////////////////////////////////////////////////////////////////////////

   dds_wave_if i_wave_if ();

   dds_core i_dds_core
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .rate_fast      (rate_fast),
      .wave           (i_wave_if.gen)
   );

   // scope sample rate
   tick_divider #(.div(sample_div)) i_sample_tick
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tick           (sample_tick)
   );

   sample_select i_sample_select
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .signal_select  (signal_select),
      .strobe         (sample_tick),
      .wave           (i_wave_if.user),
      .sample         (sample),
      .sample_strobe  (sample_strobe)
   );

   ////////////////////////////////////////////////////////////////////////////
   // keyboard
   ////////////////////////////////////////////////////////////////////////////

   key_state_tracker i_key_tracker
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_ready    (event_ready),
      .event_code     (event_code),
      .keys           (keys)
   );

endmodule

`default_nettype wire

// File: logic/key_state_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module key_state_tracker
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                event_ready,
   input  kbd_pkg::scan_event_e event_code,
   output kbd_pkg::held_keys_t keys
);

   logic [7:0]        code_raw;
   logic [6:0]        key_code;
   logic              code_valid;
   logic              is_break;
   kbd_pkg::key_idx_e key_idx;

   assign code_raw = event_code;
   assign key_code = code_raw[6:0];
   assign is_break = code_raw[7];

   // only 1..NUM_KEYS name a key and anything else is ignored
   assign code_valid = (key_code != 7'd0) && (key_code <= 7'(kbd_pkg::NUM_KEYS));
   assign key_idx    = kbd_pkg::key_idx_e'(5'(key_code - 7'd1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         keys <= '0;
      end
      else if (event_ready && code_valid)
      begin
         keys[key_idx] <= !is_break;   // make sets and break clears
      end
   end

endmodule

`default_nettype wire

// File: logic/sample_select.sv
`timescale 1ns/1ns
`default_nettype none

module sample_select
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_pkg::wave_sel_e    signal_select,
   input  logic                  strobe,
   dds_wave_if.user              wave,
   output dds_pkg::wave_sample_t sample,
   output logic                  sample_strobe
);

   dds_pkg::wave_sample_t selected;

   // mux stage, follows the selector every cycle
   always_ff @(posedge CLK_25MHZ)
   begin
      case (signal_select)
         dds_pkg::WAVE_SINE:   selected <= wave.sin_w;
         dds_pkg::WAVE_COS:    selected <= wave.cos_w;
         dds_pkg::WAVE_SAW:    selected <= wave.saw_w;
         dds_pkg::WAVE_SQUARE: selected <= wave.squ_w;
         default:              selected <= wave.sin_w;
      endcase
   end

   // hold stage, loads only on the sample strobe
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sample        <= '0;
         sample_strobe <= 1'b0;
      end
      else
      begin
         sample_strobe <= strobe;      // marks the cycle with a new sample
         if (strobe)
         begin
            sample <= selected;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/dds_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "dds_macros.svh"

module dds_core
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  logic      rate_fast,
   dds_wave_if.gen   wave
);

   dds_pkg::phase_t       phase;
   dds_pkg::phase_t       phase_inc;
   logic [11:0]           p;            // table address, top of the phase
   logic [11:0]           p_cos;
   dds_pkg::wave_sample_t sin_val;
   dds_pkg::wave_sample_t cos_val;
   dds_pkg::wave_sample_t saw_val;
   dds_pkg::wave_sample_t squ_val;

   assign phase_inc = rate_fast ? `DDS_INC_FAST : `DDS_INC_SLOW;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;   // wraps naturally
      end
   end

   assign p     = phase[`DDS_PHASE_W-1 -: `DDS_OUT_W];
   assign p_cos = p + 12'd1024;        // quarter turn ahead

   sine_lookup i_sin_lookup
   (
      .phase (p),
      .value (sin_val)
   );

   sine_lookup i_cos_lookup
   (
      .phase (p_cos),
      .value (cos_val)
   );

   assign saw_val = dds_pkg::wave_sample_t'(p);
   assign squ_val = p[11] ? dds_pkg::WAVE_MIN : dds_pkg::WAVE_MAX;

   // output stage, one cycle behind the phase
   always_ff @(posedge CLK_25MHZ)
   begin
      wave.sin_w <= sin_val;
      wave.cos_w <= cos_val;
      wave.saw_w <= saw_val;
      wave.squ_w <= squ_val;
   end

endmodule

`default_nettype wire

// File: logic/sine_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module sine_lookup
(
   input  logic [11:0]           phase,
   output dds_pkg::wave_sample_t value
);

   ////////////////////////////////////////////////////////////////////////////
   // quarter wave table
   ////////////////////////////////////////////////////////////////////////////

   // entry i holds round(2047 * sin(pi/2 * (i + 0.5) / 64))
   // centred samples make the mirrored quadrants line up exactly
   localparam logic [10:0] quarter_rom [64] = '{
      11'd25,   11'd75,   11'd126,  11'd176,  11'd226,  11'd275,  11'd325,  11'd375,
      11'd424,  11'd473,  11'd522,  11'd570,  11'd618,  11'd666,  11'd713,  11'd760,
      11'd806,  11'd852,  11'd898,  11'd943,  11'd987,  11'd1031, 11'd1074, 11'd1116,
      11'd1158, 11'd1199, 11'd1239, 11'd1279, 11'd1318, 11'd1356, 11'd1393, 11'd1430,
      11'd1465, 11'd1500, 11'd1533, 11'd1566, 11'd1598, 11'd1629, 11'd1659, 11'd1688,
      11'd1716, 11'd1743, 11'd1769, 11'd1793, 11'd1817, 11'd1840, 11'd1861, 11'd1881,
      11'd1901, 11'd1919, 11'd1936, 11'd1951, 11'd1966, 11'd1979, 11'd1992, 11'd2003,
      11'd2012, 11'd2021, 11'd2028, 11'd2035, 11'd2039, 11'd2043, 11'd2046, 11'd2047
   };

   ////////////////////////////////////////////////////////////////////////////
   // quadrant folding
   ////////////////////////////////////////////////////////////////////////////

   logic [1:0]            quadrant;
   logic [5:0]            fine_idx;
   logic [5:0]            rom_addr;
   dds_pkg::wave_sample_t magnitude;

   assign quadrant = phase[11:10];
   assign fine_idx = phase[9:4];     // low 4 bits fall inside one table step

   // falling quarters read the table backwards
   assign rom_addr = quadrant[0] ? ~fine_idx : fine_idx;

   assign magnitude = {1'b0, quarter_rom[rom_addr]};

   // lower half of the cycle is the negative lobe
   assign value = quadrant[1] ? -magnitude : magnitude;

endmodule

`default_nettype wire

// File: logic/rate_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

`include "dds_macros.svh"

module rate_lfsr
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   input  logic tick,
   output logic rate_fast
);

   logic [`LFSR_W-1:0] state;
   logic               feedback;

   // taps 5 and 3 give the maximal length of 31 states
   assign feedback = state[`LFSR_W-1] ^ state[`LFSR_W-3];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         state <= `LFSR_SEED;
      end
      else if (tick)
      begin
         state <= {state[`LFSR_W-2:0], feedback};   // shift up with the new bit at 0
      end
   end

   assign rate_fast = state[0];

   // all-zero state locks up the sequence and freezes the rate
   a_state_live: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      state != '0);

endmodule

`default_nettype wire

// File: logic/tick_divider.sv
`timescale 1ns/1ns
`default_nettype none

module tick_divider
#(
   parameter int unsigned div = 2
)
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic tick
);

   localparam int cnt_w = (div > 1) ? $clog2(div) : 1;

   logic [cnt_w-1:0] cnt;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         cnt  <= '0;
         tick <= 1'b0;
      end
      else if (cnt == cnt_w'(div - 1))
      begin
         cnt  <= '0;                 // wrap and fire
         tick <= 1'b1;
      end
      else
      begin
         cnt  <= cnt + 1'b1;
         tick <= 1'b0;
      end
   end

   // a single cycle pulse, so downstream sees one event per period
   a_tick_single: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      ((div > 1) && tick) |=> !tick);

endmodule

`default_nettype wire

// File: logic/dds_wave_if.sv
`timescale 1ns/1ns
`default_nettype none

// the four generated waveforms, all registered in the core
interface dds_wave_if;

   dds_pkg::wave_sample_t sin_w;
   dds_pkg::wave_sample_t cos_w;
   dds_pkg::wave_sample_t saw_w;
   dds_pkg::wave_sample_t squ_w;

   modport gen
   (
      output sin_w, cos_w, saw_w, squ_w
   );

   modport user
   (
      input sin_w, cos_w, saw_w, squ_w
   );

endinterface

`default_nettype wire

// File: logic/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

   localparam int NUM_KEYS = 17;

   // bit position of each key in the held vector
   typedef enum logic [4:0]
   {
      KEY_DOWN = 5'd0, KEY_UP, KEY_RIGHT, KEY_LEFT, KEY_SPACE,
      KEY_M, KEY_N, KEY_F2, KEY_F1,
      KEY_8, KEY_7, KEY_6, KEY_5, KEY_4, KEY_3, KEY_2,
      KEY_1                                        // position 16
   } key_idx_e;

   typedef logic [NUM_KEYS-1:0] held_keys_t;     // indexed by key_idx_e

   // make code is key position + 1, break adds bit 7
   typedef enum logic [7:0]
   {
      SC_NONE        = 8'h00,
      SC_MAKE_DOWN   = 8'h01, SC_BREAK_DOWN  = 8'h81,
      SC_MAKE_UP     = 8'h02, SC_BREAK_UP    = 8'h82,
      SC_MAKE_RIGHT  = 8'h03, SC_BREAK_RIGHT = 8'h83,
      SC_MAKE_LEFT   = 8'h04, SC_BREAK_LEFT  = 8'h84,
      SC_MAKE_SPACE  = 8'h05, SC_BREAK_SPACE = 8'h85,
      SC_MAKE_M      = 8'h06, SC_BREAK_M     = 8'h86,
      SC_MAKE_N      = 8'h07, SC_BREAK_N     = 8'h87,
      SC_MAKE_F2     = 8'h08, SC_BREAK_F2    = 8'h88,
      SC_MAKE_F1     = 8'h09, SC_BREAK_F1    = 8'h89,
      SC_MAKE_8      = 8'h0A, SC_BREAK_8     = 8'h8A,
      SC_MAKE_7      = 8'h0B, SC_BREAK_7     = 8'h8B,
      SC_MAKE_6      = 8'h0C, SC_BREAK_6     = 8'h8C,
      SC_MAKE_5      = 8'h0D, SC_BREAK_5     = 8'h8D,
      SC_MAKE_4      = 8'h0E, SC_BREAK_4     = 8'h8E,
      SC_MAKE_3      = 8'h0F, SC_BREAK_3     = 8'h8F,
      SC_MAKE_2      = 8'h10, SC_BREAK_2     = 8'h90,
      SC_MAKE_1      = 8'h11, SC_BREAK_1     = 8'h91
   } scan_event_e;

endpackage

`default_nettype wire

// File: logic/dds_pkg.sv
`default_nettype none

`include "dds_macros.svh"

package dds_pkg;

   // one signed sample, two's complement around zero
   typedef logic signed [`DDS_OUT_W-1:0] wave_sample_t;

   // accumulator phase, wraps at 2^32
   typedef logic [`DDS_PHASE_W-1:0] phase_t;

   // waveform shown on the scope
   typedef enum logic [1:0]
   {
      WAVE_SINE   = 2'd0,
      WAVE_COS    = 2'd1,
      WAVE_SAW    = 2'd2,
      WAVE_SQUARE = 2'd3
   } wave_sel_e;

   // full scale of a sample
   localparam wave_sample_t WAVE_MAX = 12'sh7FF;   // +2047
   localparam wave_sample_t WAVE_MIN = 12'sh800;   // -2048

endpackage

`default_nettype wire

// File: logic/dds_macros.svh
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

// datapath widths
`define DDS_PHASE_W     32              // phase accumulator
`define DDS_OUT_W       12              // one waveform sample

// phase steps per clock, picked by the lfsr
`define DDS_INC_SLOW    32'h0000_0056
`define DDS_INC_FAST    32'h0000_0102

// rate lfsr
`define LFSR_W          5
`define LFSR_SEED       5'b00001        // lsb set, starts on the fast rate

// default divider periods at 25 MHz
`define RATE_TICK_DIV   25_000_000      // one lfsr step per second
`define SAMPLE_DIV      70_000          // scope sample rate

`endif
